// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rv_core_ex
FILELIST = vlog.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// ==== rv_alu1.sv ====
`timescale 1ns/1ps

module rv_alu1
#(
    parameter int IADDR_BITS = 16
)
(
    input  logic                   i_clk,
    input  logic                   i_arst_n,
    input  logic                   i_stall,
    input  logic                   i_flush,
    input  rv_pipe_pkg::dec_ctrl_t i_ctrl,
    input  rv_isa_pkg::word_t      i_pc,
    input  rv_isa_pkg::word_t      i_rdata1,
    input  rv_isa_pkg::word_t      i_rdata2,
    output rv_pipe_pkg::ex1_t      o_ex1
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam word_t PC_MASK = word_t'((64'd1 << IADDR_BITS) - 64'd1);

    dec_ctrl_t ctrl_q;
    word_t     pc_q, rdata1_q, rdata2_q;
    word_t     target_base, pc_target;
    word_t     st_data;
    byte_sel_t st_sel;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            ctrl_q   <= '0;
            pc_q     <= '0;
            rdata1_q <= '0;
            rdata2_q <= '0;
        end
        else if (i_flush)
            ctrl_q.valid <= 1'b0;           // squash the slot behind a redirect.
        else if (!i_stall)
        begin
            ctrl_q   <= i_ctrl;
            pc_q     <= i_pc & PC_MASK;
            rdata1_q <= i_rdata1;
            rdata2_q <= i_rdata2;
        end
    end

    assign target_base = (ctrl_q.is_jalr || ctrl_q.is_store) ? rdata1_q : pc_q;

    always_comb
    begin
        pc_target = target_base + ctrl_q.imm;
        if (ctrl_q.is_jalr)
            pc_target[0] = 1'b0;
        pc_target = pc_target & PC_MASK;
    end

    // replicate the store data over the lanes, select by address.
    always_comb
    begin
        case (ctrl_q.funct3)
            F3_SB:
            begin
                st_data = {4{rdata2_q[7:0]}};
                st_sel  = 4'b0001 << pc_target[1:0];
            end
            F3_SH:
            begin
                st_data = {2{rdata2_q[15:0]}};
                st_sel  = 4'b0011 << {pc_target[1], 1'b0};
            end
            default:
            begin
                st_data = rdata2_q;
                st_sel  = 4'b1111;
            end
        endcase
    end

    always_comb
    begin
        o_ex1           = '0;
        o_ex1.valid     = ctrl_q.valid;
        o_ex1.rd        = ctrl_q.rd;
        o_ex1.reg_write = ctrl_q.reg_write;
        o_ex1.alu_op    = ctrl_q.alu_op;
        o_ex1.funct3    = ctrl_q.funct3;
        o_ex1.op1       = ctrl_q.op1_pc ? pc_q : rdata1_q;
        o_ex1.op2       = ctrl_q.op2_imm ? ctrl_q.imm : rdata2_q;
        o_ex1.pc_target = pc_target;
        o_ex1.link      = (pc_q + 32'd4) & PC_MASK;
        o_ex1.is_jump   = ctrl_q.is_jal | ctrl_q.is_jalr;
        o_ex1.is_branch = ctrl_q.is_branch;
        o_ex1.is_store  = ctrl_q.is_store;
        o_ex1.st_data   = st_data;
        o_ex1.st_sel    = st_sel;
    end

    a_store_no_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        ctrl_q.valid && ctrl_q.is_store |-> !ctrl_q.reg_write);

endmodule

// ==== rv_alu2.sv ====
`timescale 1ns/1ps

module rv_alu2
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_stall,
    input  rv_pipe_pkg::ex1_t  i_ex1,
    output rv_pipe_pkg::ex2_t  o_ex2,
    output logic               o_redirect,
    output rv_isa_pkg::word_t  o_redirect_pc
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    word_t op1, op2, alu_res;
    logic  eq, lt, ltu, cond;
    ex2_t  ex2_q;
    logic  taken_q;
    word_t target_q;

    assign op1 = i_ex1.op1;
    assign op2 = i_ex1.op2;
    assign eq  = (op1 == op2);
    assign lt  = ($signed(op1) < $signed(op2));
    assign ltu = (op1 < op2);

    always_comb
    begin
        case (i_ex1.alu_op)
            ALU_ADD:  alu_res = op1 + op2;
            ALU_SUB:  alu_res = op1 - op2;
            ALU_SLL:  alu_res = op1 << op2[4:0];
            ALU_SLT:  alu_res = word_t'(lt);
            ALU_SLTU: alu_res = word_t'(ltu);
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SRL:  alu_res = op1 >> op2[4:0];
            ALU_SRA:  alu_res = word_t'($signed(op1) >>> op2[4:0]);
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            default:  alu_res = op2;        // pass-op2.
        endcase
    end

    always_comb
    begin
        case (br_cond_t'(i_ex1.funct3))
            BR_EQ:   cond = eq;
            BR_NE:   cond = !eq;
            BR_LT:   cond = lt;
            BR_GE:   cond = !lt;
            BR_LTU:  cond = ltu;
            BR_GEU:  cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            ex2_q    <= '0;
            taken_q  <= 1'b0;
            target_q <= '0;
        end
        else if (o_redirect)
            ex2_q.valid <= 1'b0;            // wrong-path slot.
        else if (!i_stall)
        begin
            ex2_q.valid     <= i_ex1.valid;
            ex2_q.rd        <= i_ex1.rd;
            ex2_q.reg_write <= i_ex1.reg_write;
            ex2_q.result    <= alu_res;
            ex2_q.link      <= i_ex1.link;
            ex2_q.is_jump   <= i_ex1.is_jump;
            ex2_q.is_store  <= i_ex1.is_store;
            ex2_q.st_addr   <= i_ex1.pc_target;
            ex2_q.st_data   <= i_ex1.st_data;
            ex2_q.st_sel    <= i_ex1.st_sel;
            taken_q         <= i_ex1.is_jump | (i_ex1.is_branch & cond);
            target_q        <= i_ex1.pc_target;
        end
    end

    assign o_ex2         = ex2_q;
    assign o_redirect    = ex2_q.valid & taken_q & !i_stall;   // held back while stalled.
    assign o_redirect_pc = target_q;

    a_no_redirect_in_stall: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_stall |-> !o_redirect);

endmodule

// ==== rv_core_ex.sv ====
`timescale 1ns/1ps

module rv_core_ex
#(
    parameter int IADDR_BITS = 16
)
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  rv_isa_pkg::word_t     i_instr,
    input  rv_isa_pkg::word_t     i_pc,
    input  logic                  i_stall,
    output logic                  o_wb_valid,
    output rv_isa_pkg::reg_idx_t  o_wb_rd,
    output rv_isa_pkg::word_t     o_wb_data,
    output logic                  o_st_valid,
    output rv_isa_pkg::word_t     o_st_addr,
    output rv_isa_pkg::word_t     o_st_data,
    output rv_isa_pkg::byte_sel_t o_st_sel,
    output logic                  o_redirect,
    output rv_isa_pkg::word_t     o_redirect_pc
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    dec_ctrl_t ctrl;
    ex1_t      ex1;
    ex2_t      ex2;
    word_t     rdata1, rdata2, wdata;
    reg_idx_t  wrd;
    logic      we;

    rv_decode u_decode
    (
        .i_valid  (i_valid),
        .i_instr  (i_instr),
        .o_ctrl   (ctrl)
    );

    rv_regfile u_regfile
    (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_rs1    (ctrl.rs1),
        .i_rs2    (ctrl.rs2),
        .o_rdata1 (rdata1),
        .o_rdata2 (rdata2),
        .i_we     (we),
        .i_wrd    (wrd),
        .i_wdata  (wdata),
        .i_hold   (i_stall)
    );

    rv_alu1
    #(
        .IADDR_BITS (IADDR_BITS)
    )
    u_alu1
    (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .i_flush  (o_redirect),     // redirect doubles as flush.
        .i_ctrl   (ctrl),
        .i_pc     (i_pc),
        .i_rdata1 (rdata1),
        .i_rdata2 (rdata2),
        .o_ex1    (ex1)
    );

    rv_alu2 u_alu2
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_stall       (i_stall),
        .i_ex1         (ex1),
        .o_ex2         (ex2),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    rv_result u_result
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_stall    (i_stall),
        .i_ex2      (ex2),
        .o_we       (we),
        .o_wrd      (wrd),
        .o_wdata    (wdata),
        .o_wb_valid (o_wb_valid),
        .o_wb_rd    (o_wb_rd),
        .o_wb_data  (o_wb_data),
        .o_st_valid (o_st_valid),
        .o_st_addr  (o_st_addr),
        .o_st_data  (o_st_data),
        .o_st_sel   (o_st_sel)
    );

endmodule

// ==== rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode
(
    input  logic                   i_valid,
    input  rv_isa_pkg::word_t      i_instr,
    output rv_pipe_pkg::dec_ctrl_t o_ctrl
);
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    opcode_t   opc;
    funct3_t   funct3;
    logic      alt;                     // bit 30, sub and sra.
    word_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    alu_op_t   arith_op;
    dec_ctrl_t ctrl;

    assign opc    = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign alt    = i_instr[30];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb
    begin
        case (funct3)
            3'b000:  arith_op = (alt && opc == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    // branches compare rs1 with rs2, their pc-relative target comes from rv_alu1.
    always_comb
    begin
        ctrl        = '0;
        ctrl.valid  = i_valid;
        ctrl.rs1    = i_instr[19:15];
        ctrl.rs2    = i_instr[24:20];
        ctrl.rd     = i_instr[11:7];
        ctrl.funct3 = funct3;
        ctrl.imm    = imm_i;
        ctrl.alu_op = ALU_ADD;
        case (opc)
            OPC_OP:
            begin
                ctrl.alu_op    = arith_op;
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM:
            begin
                ctrl.alu_op    = arith_op;
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_LUI:
            begin
                ctrl.rs1       = '0;
                ctrl.imm       = imm_u;
                ctrl.alu_op    = ALU_PASS2;
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_AUIPC:
            begin
                ctrl.imm       = imm_u;
                ctrl.op1_pc    = 1'b1;
                ctrl.op2_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_JAL:
            begin
                ctrl.imm       = imm_j;
                ctrl.op1_pc    = 1'b1;
                ctrl.op2_imm   = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_JALR:
            begin
                ctrl.op2_imm   = 1'b1;
                ctrl.is_jalr   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_BRANCH:
            begin
                ctrl.imm       = imm_b;
                ctrl.is_branch = 1'b1;
            end
            OPC_STORE:
            begin
                ctrl.imm       = imm_s;
                ctrl.is_store  = 1'b1;
            end
            default: ctrl.valid = 1'b0;     // bubble.
        endcase
    end

    assign o_ctrl = ctrl;

    always_comb
    begin
        if (o_ctrl.valid)
            assert (!$isunknown(o_ctrl.alu_op))
            else $error("rv_decode: valid instruction with unknown alu_op");
    end

endmodule

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [3:0]  byte_sel_t;    // one enable per byte lane.

    // major opcodes of the supported subset.
    typedef enum logic [6:0] {
        OPC_OP      = 7'b0110011,
        OPC_OP_IMM  = 7'b0010011,
        OPC_LUI     = 7'b0110111,
        OPC_AUIPC   = 7'b0010111,
        OPC_JAL     = 7'b1101111,
        OPC_JALR    = 7'b1100111,
        OPC_BRANCH  = 7'b1100011,
        OPC_STORE   = 7'b0100011,
        OPC_ILLEGAL = 7'b0000000
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS2    // lui.
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_t;

    // store sizes.
    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;

endpackage

// ==== rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    // decoded instruction, decode to rv_alu1.
    typedef struct packed {
        logic                 valid;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::word_t    imm;
        rv_isa_pkg::funct3_t  funct3;
        rv_isa_pkg::alu_op_t  alu_op;
        logic                 op1_pc;
        logic                 op2_imm;
        logic                 reg_write;
        logic                 is_jal;
        logic                 is_jalr;
        logic                 is_branch;
        logic                 is_store;
    } dec_ctrl_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_idx_t  rd;
        logic                  reg_write;
        rv_isa_pkg::alu_op_t   alu_op;
        rv_isa_pkg::funct3_t   funct3;
        rv_isa_pkg::word_t     op1;
        rv_isa_pkg::word_t     op2;
        rv_isa_pkg::word_t     pc_target;
        rv_isa_pkg::word_t     link;
        logic                  is_jump;
        logic                  is_branch;
        logic                  is_store;
        rv_isa_pkg::word_t     st_data;
        rv_isa_pkg::byte_sel_t st_sel;
    } ex1_t;

    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::reg_idx_t  rd;
        logic                  reg_write;
        rv_isa_pkg::word_t     result;
        rv_isa_pkg::word_t     link;
        logic                  is_jump;
        logic                  is_store;
        rv_isa_pkg::word_t     st_addr;
        rv_isa_pkg::word_t     st_data;
        rv_isa_pkg::byte_sel_t st_sel;
    } ex2_t;

endpackage

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile
(
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  rv_isa_pkg::reg_idx_t i_rs1,
    input  rv_isa_pkg::reg_idx_t i_rs2,
    output rv_isa_pkg::word_t    o_rdata1,
    output rv_isa_pkg::word_t    o_rdata2,
    input  logic                 i_we,
    input  rv_isa_pkg::reg_idx_t i_wrd,
    input  rv_isa_pkg::word_t    i_wdata,
    input  logic                 i_hold
);
    import rv_isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            regs <= '{default: '0};
        else if (i_we && !i_hold && i_wrd != '0)
            regs[i_wrd] <= i_wdata;
    end

    // x0 is hardwired.
    assign o_rdata1 = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rdata2 = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// ==== rv_result.sv ====
`timescale 1ns/1ps

module rv_result
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_stall,
    input  rv_pipe_pkg::ex2_t     i_ex2,
    output logic                  o_we,
    output rv_isa_pkg::reg_idx_t  o_wrd,
    output rv_isa_pkg::word_t     o_wdata,
    output logic                  o_wb_valid,
    output rv_isa_pkg::reg_idx_t  o_wb_rd,
    output rv_isa_pkg::word_t     o_wb_data,
    output logic                  o_st_valid,
    output rv_isa_pkg::word_t     o_st_addr,
    output rv_isa_pkg::word_t     o_st_data,
    output rv_isa_pkg::byte_sel_t o_st_sel
);
    import rv_isa_pkg::*;

    logic  we;
    word_t wdata;

    assign we    = i_ex2.valid & i_ex2.reg_write & (i_ex2.rd != '0);
    assign wdata = i_ex2.is_jump ? i_ex2.link : i_ex2.result;

    // the register file is written at the same edge that loads the ports.
    assign o_we    = we;
    assign o_wrd   = i_ex2.rd;
    assign o_wdata = wdata;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_wb_valid <= 1'b0;
            o_wb_rd    <= '0;
            o_wb_data  <= '0;
            o_st_valid <= 1'b0;
            o_st_addr  <= '0;
            o_st_data  <= '0;
            o_st_sel   <= '0;
        end
        else
        begin
            o_wb_valid <= we & !i_stall;
            o_wb_rd    <= i_ex2.rd;
            o_wb_data  <= wdata;
            o_st_valid <= i_ex2.valid & i_ex2.is_store & !i_stall;
            o_st_addr  <= i_ex2.st_addr;
            o_st_data  <= i_ex2.st_data;
            o_st_sel   <= i_ex2.st_sel;
        end
    end

endmodule

// ==== tb_rv_core_ex.sv ====
`timescale 1ns/1ps

module tb_rv_core_ex;
    import rv_isa_pkg::*;

    localparam int          IADDR_BITS  = 16;
    localparam logic [31:0] PC_MASK     = 32'h0000_ffff;
    localparam int          CYCLE_LIMIT = 2000;    // six tests at about 4 cycles per instruction.

    typedef struct packed {
        logic        wb;
        logic [4:0]  rd;
        logic [31:0] wdata;
        logic        st;
        logic [31:0] st_addr;
        logic [31:0] st_data;
        logic [3:0]  st_sel;
        logic        redirect;
        logic [31:0] target;
    } expect_t;

    logic      i_clk = 1'b0;
    logic      i_arst_n;
    logic      i_valid;
    word_t     i_instr;
    word_t     i_pc;
    logic      i_stall;
    logic      o_wb_valid;
    reg_idx_t  o_wb_rd;
    word_t     o_wb_data;
    logic      o_st_valid;
    word_t     o_st_addr;
    word_t     o_st_data;
    byte_sel_t o_st_sel;
    logic      o_redirect;
    word_t     o_redirect_pc;

    integer      seed = 32'h4f41;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          test_errors;
    int          test_checks;
    int          tests_run = 0;
    string       cur_test = "reset";
    logic [31:0] ref_regs [32];
    logic [36:0] wb_q [$];
    logic [67:0] st_q [$];
    logic [31:0] rdr_q [$];
    logic [36:0] exp_wb;
    logic [67:0] exp_st;
    logic [31:0] exp_rdr;
    logic        stall_prev = 1'b0;

    rv_core_ex #(.IADDR_BITS(IADDR_BITS)) i_rv_core_ex
    (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_valid       (i_valid),
        .i_instr       (i_instr),
        .i_pc          (i_pc),
        .i_stall       (i_stall),
        .o_wb_valid    (o_wb_valid),
        .o_wb_rd       (o_wb_rd),
        .o_wb_data     (o_wb_data),
        .o_st_valid    (o_st_valid),
        .o_st_addr     (o_st_addr),
        .o_st_data     (o_st_data),
        .o_st_sel      (o_st_sel),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("timeout after %0d cycles in test %s", cycles, cur_test);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic report_error(input string what);
        $display("[FAIL] %s: %s", cur_test, what);
        errors++;
        test_errors++;
    endtask

    task automatic report_value(input string what, input logic [67:0] exp, input logic [67:0] act);
        $display("[FAIL] %s %s expected %h actual %h", cur_test, what, exp, act);
        errors++;
        test_errors++;
    endtask

    // outputs are sampled before this edge's updates.
    always @(posedge i_clk)
    begin
        if (i_arst_n)
        begin
            if (o_wb_valid)
            begin
                if (stall_prev)
                    report_error("write-back pulse appeared during a stall");
                if (wb_q.size() == 0)
                    report_error("unexpected write-back pulse");
                else
                begin
                    exp_wb = wb_q.pop_front();
                    checks++;
                    test_checks++;
                    if ({o_wb_rd, o_wb_data} != exp_wb)
                        report_value("write-back", 68'(exp_wb), 68'({o_wb_rd, o_wb_data}));
                end
            end
            if (o_st_valid)
            begin
                if (st_q.size() == 0)
                    report_error("unexpected store pulse");
                else
                begin
                    exp_st = st_q.pop_front();
                    checks++;
                    test_checks++;
                    if ({o_st_addr, o_st_data, o_st_sel} != exp_st)
                        report_value("store", exp_st, {o_st_addr, o_st_data, o_st_sel});
                end
            end
            if (o_redirect)
            begin
                if (rdr_q.size() == 0)
                    report_error("unexpected redirect pulse");
                else
                begin
                    exp_rdr = rdr_q.pop_front();
                    checks++;
                    test_checks++;
                    if (o_redirect_pc != exp_rdr)
                        report_value("redirect pc", 68'(exp_rdr), 68'(o_redirect_pc));
                end
            end
        end
        stall_prev = i_stall;
    end

    function automatic logic [31:0] rnd(input int unsigned n);
        logic [31:0] r;
        r = $random(seed);
        rnd = r % n;
    endfunction

    // expected effect of one instruction, from the RV32I rules.
    function automatic expect_t predict(input logic [31:0] instr, input logic [31:0] pc);
        expect_t     e;
        logic [31:0] a, b, pcm, res, addr;
        logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
        e     = '0;
        pcm   = pc & PC_MASK;
        a     = ref_regs[instr[19:15]];
        b     = ref_regs[instr[24:20]];
        res   = 32'h0;
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'b0};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        case (instr[6:0])
            7'b0110011, 7'b0010011:
            begin
                if (instr[6:0] == 7'b0010011)
                    b = imm_i;
                case (instr[14:12])
                    3'd0: res = (instr[30] && instr[5]) ? a - b : a + b;
                    3'd1: res = a << b[4:0];
                    3'd2: res = {31'b0, $signed(a) < $signed(b)};
                    3'd3: res = {31'b0, a < b};
                    3'd4: res = a ^ b;
                    3'd5:
                    begin
                        if (instr[30])
                            res = $signed(a) >>> b[4:0];
                        else
                            res = a >> b[4:0];
                    end
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
                e.wb = 1'b1;
            end
            7'b0110111:
            begin
                res  = imm_u;
                e.wb = 1'b1;
            end
            7'b0010111:
            begin
                res  = pcm + imm_u;
                e.wb = 1'b1;
            end
            7'b1101111, 7'b1100111:
            begin
                res        = (pcm + 32'd4) & PC_MASK;
                e.wb       = 1'b1;
                e.redirect = 1'b1;
                if (instr[3])
                    e.target = (pcm + imm_j) & PC_MASK;
                else
                    e.target = ((a + imm_i) & ~32'd1) & PC_MASK;
            end
            7'b1100011:
            begin
                case (instr[14:12])
                    3'b000: e.redirect = (a == b);
                    3'b001: e.redirect = (a != b);
                    3'b100: e.redirect = ($signed(a) < $signed(b));
                    3'b101: e.redirect = ($signed(a) >= $signed(b));
                    3'b110: e.redirect = (a < b);
                    default: e.redirect = (a >= b);
                endcase
                e.target = (pcm + imm_b) & PC_MASK;
            end
            default:
            begin
                addr      = (a + imm_s) & PC_MASK;
                e.st      = 1'b1;
                e.st_addr = addr;
                case (instr[14:12])
                    3'b000:
                    begin
                        e.st_data = {4{b[7:0]}};
                        e.st_sel  = 4'b0001 << addr[1:0];
                    end
                    3'b001:
                    begin
                        e.st_data = {2{b[15:0]}};
                        e.st_sel  = addr[1] ? 4'b1100 : 4'b0011;
                    end
                    default:
                    begin
                        e.st_data = b;
                        e.st_sel  = 4'b1111;
                    end
                endcase
            end
        endcase
        e.rd    = instr[11:7];
        e.wdata = res;
        e.wb    = e.wb && (instr[11:7] != 5'd0);
        return e;
    endfunction

    // one issue cycle; a squashed instruction is sent with live low.
    task automatic send(input logic [31:0] instr, input logic [31:0] pc, input logic live);
        expect_t e;
        @(posedge i_clk);
        i_valid <= 1'b1;
        i_instr <= instr;
        i_pc    <= pc;
        if (live)
        begin
            e = predict(instr, pc);
            if (e.wb)
            begin
                wb_q.push_back({e.rd, e.wdata});
                ref_regs[e.rd] = e.wdata;
            end
            if (e.st)
                st_q.push_back({e.st_addr, e.st_data, e.st_sel});
            if (e.redirect)
                rdr_q.push_back(e.target);
        end
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge i_clk);
            i_valid <= 1'b0;
        end
    endtask

    task automatic stall_for(input int n);
        @(posedge i_clk);
        i_valid <= 1'b0;
        i_stall <= 1'b1;
        repeat (n - 1) @(posedge i_clk);
        @(posedge i_clk);
        i_stall <= 1'b0;
    endtask

    function automatic logic [31:0] gen_alu();
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        logic        alt;
        f3  = 3'(rnd(8));
        rd  = 5'(rnd(32));
        rs1 = 5'(rnd(32));
        rs2 = 5'(rnd(32));
        imm = 12'(rnd(4096));
        alt = 1'(rnd(2));
        if (rnd(2) == 0)
            gen_alu = {1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        else if (f3 == 3'd1 || f3 == 3'd5)
            gen_alu = {1'b0, alt && f3 == 3'd5, 5'b0, imm[4:0], rs1, f3, rd, 7'b0010011};
        else
            gen_alu = {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] gen_addi(input logic [4:0] rd, input logic [4:0] rs1);
        logic [11:0] imm;
        imm      = 12'(rnd(4096));
        gen_addi = {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    task automatic begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic end_test();
        int waited;
        waited = 0;
        while ((wb_q.size() + st_q.size() + rdr_q.size()) != 0 && waited < 40)
        begin
            idle(1);
            waited++;
        end
        idle(4);    // room for a stray pulse.
        if (wb_q.size() != 0)
            report_error("expected write-back never appeared");
        if (st_q.size() != 0)
            report_error("expected store never appeared");
        if (rdr_q.size() != 0)
            report_error("expected redirect never appeared");
        wb_q.delete();
        st_q.delete();
        rdr_q.delete();
        $display("test %-8s done: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        tests_run++;
    endtask

    initial
    begin
        logic [31:0] instr, pc;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [4:0]  rd;
        logic [2:0]  conds [6];
        conds    = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_instr  = '0;
        i_pc     = '0;
        i_stall  = 1'b0;
        for (int r = 0; r < 32; r++)
            ref_regs[r] = 32'h0;
        repeat (2) @(posedge i_clk);
        i_arst_n <= 1'b1;
        idle(2);

        begin_test("alu");
        for (int k = 0; k < 60; k++)
        begin
            instr = gen_alu();
            if (k % 8 == 7)
                instr[11:7] = 5'd0;
            send(instr, 32'h100 + 4 * k, 1'b1);
            idle(3);
        end
        end_test();

        begin_test("upper");
        for (int k = 0; k < 20; k++)
        begin
            instr = {20'(rnd(32'h100000)), 5'(rnd(31) + 1), (k % 2) ? 7'b0010111 : 7'b0110111};
            send(instr, $random(seed) & ~32'd3, 1'b1);
            idle(3);
        end
        end_test();

        begin_test("store");
        for (int k = 0; k < 40; k++)
        begin
            instr = {7'(rnd(128)), 5'(rnd(32)), 5'(rnd(32)), 3'(rnd(3)), 5'(rnd(32)), 7'b0100011};
            send(instr, 32'h200 + 4 * k, 1'b1);
            idle(3);
        end
        end_test();

        begin_test("branch");
        for (int k = 0; k < 40; k++)
        begin
            boff  = {12'(rnd(4096)), 1'b0};
            instr = {boff[12], boff[10:5], 5'(rnd(32)), 5'(rnd(32)), conds[rnd(6)],
                     boff[4:1], boff[11], 7'b1100011};
            if (rnd(4) == 0)
                instr[24:20] = instr[19:15];
            send(instr, 32'h400 + 4 * k, 1'b1);
            idle(3);
        end
        end_test();

        begin_test("jump");
        for (int k = 0; k < 10; k++)
        begin
            rd = 5'(rnd(31) + 1);
            pc = 32'h800 + 32 * k;
            joff = {20'(rnd(32'h100000)), 1'b0};
            if (k % 2)
                instr = {12'(rnd(4096)), 5'(rnd(32)), 3'b000, rd, 7'b1100111};
            else
                instr = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
            send(instr, pc, 1'b1);
            send(gen_addi(5'(rnd(31) + 1), 5'(rnd(32))), pc + 4, 1'b0);
            send(gen_addi(5'(rnd(31) + 1), 5'(rnd(32))), pc + 8, 1'b0);
            send(gen_addi(5'(rnd(31) + 1), rd), pc + 12, 1'b1);   // reads the link.
            idle(4);
        end
        end_test();

        begin_test("stall");
        for (int k = 0; k < 30; k++)
        begin
            send(gen_alu(), 32'hc00 + 4 * k, 1'b1);
            idle(rnd(3));
            stall_for(rnd(6) + 1);
            idle(3);
        end
        end_test();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== vlog.f ====
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_decode.sv
rv_regfile.sv
rv_alu1.sv
rv_alu2.sv
rv_result.sv
rv_core_ex.sv
tb_rv_core_ex.sv
